// ==== source/ll_pkg.sv ====
`default_nettype none

package ll_pkg;

  ////////////////////
  // AXI field widths
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_size_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [47:0] axi_addr_t;
  typedef logic [1:0]  axi_resp_t;

  ////////////////////
  // Packed channel payloads

  // {id, size, len, burst, addr}
  typedef logic [63:0] ar_payload_t;
  // {id, resp}
  typedef logic [5:0]  b_payload_t;

  ////////////////////
  // Link control
  typedef logic [7:0]  credit_t;
  typedef logic [15:0] delay_t;

  // Transmit word is {b credit, ar payload, ar push}
  typedef logic [65:0] tx_phy_t;
  // Receive word is {ar credit, b payload, b push}
  typedef logic [7:0]  rx_phy_t;

  // Room for the B responses the far side may send unasked
  parameter int RX_FIFO_DEPTH_DEFAULT = 8;

endpackage

`default_nettype wire

// ==== source/ll_link_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ll_link_if
  import ll_pkg::*;
();

  // AR direction, toward the PHY
  logic        tx_pushbit;
  ar_payload_t tx_data;
  logic        rx_credit;

  // B direction, from the PHY
  logic        rx_pushbit;
  b_payload_t  rx_data;
  logic        tx_credit;

  modport transmit (
    output tx_pushbit,
    output tx_data,
    input  rx_credit
  );

  modport receive (
    output tx_credit,
    input  rx_pushbit,
    input  rx_data
  );

  modport phy (
    input  tx_pushbit,
    input  tx_data,
    input  tx_credit,
    output rx_pushbit,
    output rx_data,
    output rx_credit
  );

endinterface

`default_nettype wire

// ==== source/ll_online_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module ll_online_sync
  import ll_pkg::*;
(
  input  logic   clk_wr,
  input  logic   reset,
  input  logic   tx_online,
  input  logic   rx_online,
  input  delay_t delay_value,
  output logic   tx_online_delay,
  output logic   rx_online_delay
);

  // Index 0 is transmit, index 1 is receive
  logic [1:0] online_in;
  logic [1:0] online_out;
  delay_t     count [2];

  assign online_in = {rx_online, tx_online};

  ////////////////////
  // Delay counters

  // Each counter runs while its input is high and stops at the
  // delay value. The flag follows on the next edge and drops
  // one cycle after the input drops.
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (reset || !online_in[i]) begin
        count[i]      <= '0;
        online_out[i] <= 1'b0;
      end else if (count[i] >= delay_value) begin
        online_out[i] <= 1'b1;
      end else begin
        count[i] <= count[i] + 16'd1;
      end
    end
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

endmodule

`default_nettype wire

// ==== source/ll_transmit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ll_transmit
  import ll_pkg::*;
(
  input  logic       clk_wr,
  input  logic       reset,
  input  logic       tx_online_delay,
  input  credit_t    init_ar_credit,

  input  axi_id_t    user_arid,
  input  axi_size_t  user_arsize,
  input  axi_len_t   user_arlen,
  input  axi_burst_t user_arburst,
  input  axi_addr_t  user_araddr,
  input  logic       user_arvalid,
  output logic       user_arready,

  ll_link_if.transmit link
);

  logic        buf_full;
  ar_payload_t buf_data;
  credit_t     credit;
  logic        accept;
  logic        push;

  ////////////////////
  // User side
  assign user_arready = tx_online_delay && !buf_full;
  assign accept       = user_arvalid && user_arready;

  // AR fields packed into the one-entry buffer
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      buf_data <= {user_arid, user_arsize, user_arlen, user_arburst, user_araddr};
    end
  end

  // Buffer leaves as a push only when the far side has room
  assign push = buf_full && (credit != '0) && tx_online_delay;

  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      buf_full <= 1'b0;
    end else if (accept) begin
      buf_full <= 1'b1;
    end else if (push) begin
      buf_full <= 1'b0;
    end
  end

  ////////////////////
  // Credit counter

  // Loaded while offline; a push and a returned credit cancel out
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit <= '0;
    end else if (!tx_online_delay) begin
      credit <= init_ar_credit;
    end else if (link.rx_credit && !push) begin
      credit <= credit + 8'd1;
    end else if (push && !link.rx_credit) begin
      credit <= credit - 8'd1;
    end
  end

  assign link.tx_pushbit = push;
  assign link.tx_data    = buf_data;

endmodule

`default_nettype wire

// ==== source/ll_receive.sv ====
`timescale 1ns/10ps
`default_nettype none

module ll_receive
  import ll_pkg::*;
#(
  parameter int RX_FIFO_DEPTH = 8
) (
  input  logic      clk_wr,
  input  logic      reset,
  input  logic      rx_online_delay,

  output axi_id_t   user_bid,
  output axi_resp_t user_bresp,
  output logic      user_bvalid,
  input  logic      user_bready,

  ll_link_if.receive link
);

  localparam int AW = $clog2(RX_FIFO_DEPTH);

  // Extra top bit tells full from empty
  typedef logic [AW:0] ptr_t;

  b_payload_t mem [RX_FIFO_DEPTH];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  logic       full;
  logic       empty;
  logic       push;
  logic       pop;
  b_payload_t head;
  logic       credit_out;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Overflow means the far end broke credit; the word is lost
  assign push = link.rx_pushbit && rx_online_delay && !full;
  assign pop  = user_bvalid && user_bready;

  ////////////////////
  // Storage
  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= link.rx_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////
  // User side, first word fall through
  assign head        = mem[rd_ptr[AW-1:0]];
  assign user_bvalid = !empty;
  assign user_bid    = head[5:2];
  assign user_bresp  = head[1:0];

  // One freed entry, one credit back to the far end
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_out <= 1'b0;
    end else begin
      credit_out <= pop;
    end
  end

  assign link.tx_credit = credit_out;

endmodule

`default_nettype wire

// ==== source/ll_phy_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module ll_phy_link
  import ll_pkg::*;
(
  input  logic    clk_wr,
  input  logic    reset,
  input  rx_phy_t rx_phy0,
  output tx_phy_t tx_phy0,

  ll_link_if.phy  link
);

  rx_phy_t rx_word;

  ////////////////////
  // Transmit word

  // Bit 0 AR push, 64..1 AR payload, 65 B credit
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= {link.tx_credit, link.tx_data, link.tx_pushbit};
    end
  end

  ////////////////////
  // Receive word

  // Whole word is registered so push and credit stay aligned
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_word <= '0;
    end else begin
      rx_word <= rx_phy0;
    end
  end

  // Bit 0 B push, 6..1 B payload, 7 AR credit
  assign link.rx_pushbit = rx_word[0];
  assign link.rx_data    = rx_word[6:1];
  assign link.rx_credit  = rx_word[7];

endmodule

`default_nettype wire

// ==== source/axi_ar_b_master_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_ar_b_master_top
  import ll_pkg::*;
#(
  parameter int RX_FIFO_DEPTH = RX_FIFO_DEPTH_DEFAULT
) (
  input  logic       clk_wr,
  input  logic       reset,

  // Link control
  input  logic       tx_online,
  input  logic       rx_online,
  input  delay_t     delay_value,
  input  credit_t    init_ar_credit,

  // PHY words
  output tx_phy_t    tx_phy0,
  input  rx_phy_t    rx_phy0,

  // AR channel
  input  axi_id_t    user_arid,
  input  axi_size_t  user_arsize,
  input  axi_len_t   user_arlen,
  input  axi_burst_t user_arburst,
  input  axi_addr_t  user_araddr,
  input  logic       user_arvalid,
  output logic       user_arready,

  // B channel
  output axi_id_t    user_bid,
  output axi_resp_t  user_bresp,
  output logic       user_bvalid,
  input  logic       user_bready
);

  logic tx_online_delay;
  logic rx_online_delay;

  ll_link_if link ();

  ll_online_sync u_online_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_value     (delay_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ll_transmit u_transmit (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online_delay (tx_online_delay),
    .init_ar_credit  (init_ar_credit),
    .user_arid       (user_arid),
    .user_arsize     (user_arsize),
    .user_arlen      (user_arlen),
    .user_arburst    (user_arburst),
    .user_araddr     (user_araddr),
    .user_arvalid    (user_arvalid),
    .user_arready    (user_arready),
    .link            (link.transmit)
  );

  ll_receive #(
    .RX_FIFO_DEPTH (RX_FIFO_DEPTH)
  ) u_receive (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .rx_online_delay (rx_online_delay),
    .user_bid        (user_bid),
    .user_bresp      (user_bresp),
    .user_bvalid     (user_bvalid),
    .user_bready     (user_bready),
    .link            (link.receive)
  );

  ll_phy_link u_phy_link (
    .clk_wr  (clk_wr),
    .reset   (reset),
    .rx_phy0 (rx_phy0),
    .tx_phy0 (tx_phy0),
    .link    (link.phy)
  );

endmodule

`default_nettype wire

// ==== bench/tb_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_asserts
  import ll_pkg::*;
(
  input wire logic    clk_wr,
  input wire logic    reset,
  input wire logic    fifo_push,
  input wire logic    fifo_full,
  input wire logic    tx_push,
  input wire logic    rx_credit,
  input wire credit_t init_credit,
  input wire logic    arvalid,
  input wire logic    arready,
  input wire logic    online
);

  // Count of failed assertions
  int fail_count = 0;

  // Transmit bookkeeping since the link came online
  int pushes_sent;
  int credits_back;
  int held;

  always_ff @(posedge clk_wr) begin
    if (reset || !online) begin
      pushes_sent  <= 0;
      credits_back <= 0;
      held         <= 0;
    end else begin
      pushes_sent  <= pushes_sent + int'(tx_push);
      credits_back <= credits_back + int'(rx_credit);
      held         <= held + int'(arvalid && arready) - int'(tx_push);
    end
  end

  ////////////////////
  // Link protocol

  // Far end must hold back while the receive FIFO has no room
  no_overflow: assert property (@(posedge clk_wr) disable iff (reset)
    !(fifo_push && fifo_full))
    else begin
      fail_count++;
      $error("B push arrived while the receive FIFO was full");
    end

  // Pushes never outrun the loaded credit plus the credit returned
  no_push_without_credit: assert property (@(posedge clk_wr) disable iff (reset)
    tx_push |-> (pushes_sent < int'(init_credit) + credits_back))
    else begin
      fail_count++;
      $error("AR push sent with zero credit");
    end

  // Ready only while online and with nothing waiting in the buffer
  no_ready_offline: assert property (@(posedge clk_wr) disable iff (reset)
    arready |-> (online && (held == 0)))
    else begin
      fail_count++;
      $error("user_arready high while the link is offline or the buffer is full");
    end

endmodule

// Each stage ties off the ports it does not own
bind ll_receive tb_asserts u_link_asserts (
  .clk_wr      (clk_wr),
  .reset       (reset),
  .fifo_push   (link.rx_pushbit && rx_online_delay),
  .fifo_full   (full),
  .tx_push     (1'b0),
  .rx_credit   (1'b0),
  .init_credit (8'd0),
  .arvalid     (1'b0),
  .arready     (1'b0),
  .online      (1'b1)
);

bind ll_transmit tb_asserts u_link_asserts (
  .clk_wr      (clk_wr),
  .reset       (reset),
  .fifo_push   (1'b0),
  .fifo_full   (1'b0),
  .tx_push     (push),
  .rx_credit   (link.rx_credit),
  .init_credit (init_ar_credit),
  .arvalid     (user_arvalid),
  .arready     (user_arready),
  .online      (tx_online_delay)
);

`default_nettype wire

// ==== bench/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top
  import ll_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int DELAY           = 10;
  localparam int N_AR            = 4;
  localparam int N_ENTRIES       = 12;
  localparam int WATCHDOG_CYCLES = N_ENTRIES * 40 + DELAY + 16 + 100;

  // One row of the stimulus table
  typedef struct packed {
    logic        is_b;
    logic        credit_before;
    logic        stall;
    axi_id_t     id;
    axi_size_t   size;
    axi_len_t    len;
    axi_burst_t  burst;
    axi_addr_t   addr;
    axi_resp_t   resp;
    ar_payload_t exp_payload;
  } entry_t;

  logic       clk_wr, reset, tx_online, rx_online;
  delay_t     delay_value;
  credit_t    init_ar_credit;
  tx_phy_t    tx_phy0;
  rx_phy_t    rx_phy0;
  axi_id_t    user_arid, user_bid;
  axi_size_t  user_arsize;
  axi_len_t   user_arlen;
  axi_burst_t user_arburst;
  axi_addr_t  user_araddr;
  axi_resp_t  user_bresp;
  logic       user_arvalid, user_arready, user_bvalid, user_bready;

  int        errors, test_start, tests_ok, tests_bad;
  int        ar_pushes, b_credits, b_handshakes;
  integer    seed = 32'h90a61a05;
  entry_t    table_mem [N_ENTRIES];
  axi_id_t   exp_bid [$];
  axi_resp_t exp_bresp [$];

  axi_ar_b_master_top #(.RX_FIFO_DEPTH(8)) uut (.*);

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  // Pulse counters see the values from before each edge
  always @(posedge clk_wr) begin
    if (tx_phy0[0]) ar_pushes++;
    if (tx_phy0[65]) b_credits++;
    if (user_bvalid && user_bready) b_handshakes++;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

  ////////////////////
  // Compare tasks
  task report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task check_ar_payload(input string name, input ar_payload_t got, input ar_payload_t exp);
    if (got !== exp) report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task check_b(input axi_id_t got_id, input axi_resp_t got_resp,
               input axi_id_t exp_id, input axi_resp_t exp_resp);
    if ({got_id, got_resp} !== {exp_id, exp_resp}) begin
      report_failure($sformatf("mismatch user_bid/user_bresp: got %h/%h expected %h/%h",
                               got_id, got_resp, exp_id, exp_resp));
    end
  endtask

  task check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task check_count(input string name, input int got, input int exp);
    if (got != exp) report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task end_test(input string name);
    if (errors == test_start) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  ////////////////////
  // Stimulus
  task build_table();
    entry_t e;
    for (int i = 0; i < N_ENTRIES; i++) begin
      e = '0;
      e.is_b = (i >= N_AR);
      e.stall = (i == 2);
      e.credit_before = (i == 3);
      e.id = $random(seed);
      e.size = $random(seed);
      e.len = $random(seed);
      e.burst = $random(seed);
      e.addr = {$random(seed), $random(seed)};
      e.resp = $random(seed);
      e.exp_payload[47:0] = e.addr;
      e.exp_payload[49:48] = e.burst;
      e.exp_payload[57:50] = e.len;
      e.exp_payload[59:58] = e.size;
      e.exp_payload[63:60] = e.id;
      table_mem[i] = e;
    end
  endtask

  task send_credit();
    @(posedge clk_wr);
    rx_phy0 <= 8'h80;
    @(posedge clk_wr);
    rx_phy0 <= 8'h00;
  endtask

  task apply_ar(input int i);
    entry_t e;
    int     t;
    e = table_mem[i];
    if (e.credit_before) begin
      send_credit();
      repeat (3) @(posedge clk_wr);
    end
    @(posedge clk_wr);
    user_arid <= e.id;
    user_arsize <= e.size;
    user_arlen <= e.len;
    user_arburst <= e.burst;
    user_araddr <= e.addr;
    user_arvalid <= 1'b1;
    t = 0;
    @(negedge clk_wr);
    while (!user_arready && t < 40) begin
      @(negedge clk_wr);
      t++;
    end
    if (!user_arready) report_failure($sformatf("AR entry %0d was never accepted", i));
    @(posedge clk_wr);
    user_arvalid <= 1'b0;
    // Push shows two cycles after the handshake
    repeat (2) @(negedge clk_wr);
    if (!e.stall) begin
      check_flag("tx_phy0[0]", tx_phy0[0], 1'b1);
      check_ar_payload("tx_phy0[64:1]", tx_phy0[64:1], e.exp_payload);
    end else begin
      check_count("AR pushes before credit", ar_pushes, i);
      repeat (3) begin
        check_flag("tx_phy0[0]", tx_phy0[0], 1'b0);
        check_flag("user_arready", user_arready, 1'b0);
        @(negedge clk_wr);
      end
      send_credit();
      t = 0;
      @(negedge clk_wr);
      while (!tx_phy0[0] && t < 10) begin
        @(negedge clk_wr);
        t++;
      end
      if (!tx_phy0[0]) report_failure("returned credit did not release the held AR");
      check_ar_payload("tx_phy0[64:1]", tx_phy0[64:1], e.exp_payload);
    end
  endtask

  task push_b(input int i);
    entry_t  e;
    rx_phy_t w;
    e = table_mem[i];
    w = '0;
    w[0] = 1'b1;
    w[2:1] = e.resp;
    w[6:3] = e.id;
    exp_bid.push_back(e.id);
    exp_bresp.push_back(e.resp);
    @(posedge clk_wr);
    rx_phy0 <= w;
    @(posedge clk_wr);
    rx_phy0 <= '0;
    @(posedge clk_wr);
    @(negedge clk_wr);
    // bready is low, so the head stays the first word
    check_flag("user_bvalid", user_bvalid, 1'b1);
    check_b(user_bid, user_bresp, exp_bid[0], exp_bresp[0]);
  endtask

  task drain_b();
    int t;
    t = 0;
    @(posedge clk_wr);
    user_bready <= 1'b1;
    while (exp_bid.size() > 0 && t < 40) begin
      @(negedge clk_wr);
      t++;
      if (user_bvalid) begin
        check_b(user_bid, user_bresp, exp_bid.pop_front(), exp_bresp.pop_front());
      end
    end
    @(posedge clk_wr);
    user_bready <= 1'b0;
    if (exp_bid.size() > 0) report_failure("receive FIFO ran empty before all responses came out");
    @(negedge clk_wr);
    check_flag("user_bvalid", user_bvalid, 1'b0);
  endtask

  ////////////////////
  // Main sequence
  initial begin
    reset = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    delay_value = DELAY;
    init_ar_credit = 8'd2;
    rx_phy0 = '0;
    user_arid = '0;
    user_arsize = '0;
    user_arlen = '0;
    user_arburst = '0;
    user_araddr = '0;
    user_arvalid = 1'b0;
    user_bready = 1'b0;
    build_table();
    repeat (16) @(posedge clk_wr);
    reset <= 1'b0;
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    repeat (DELAY) begin
      @(negedge clk_wr);
      check_flag("user_arready", user_arready, 1'b0);
      check_flag("tx_phy0 nonzero", |tx_phy0, 1'b0);
    end
    end_test("offline hold");
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (table_mem[i].is_b) push_b(i);
      else apply_ar(i);
      end_test($sformatf("entry %0d %s", i, table_mem[i].is_b ? "B push" : "AR request"));
    end
    check_count("AR pushes", ar_pushes, N_AR);
    drain_b();
    end_test("B drain");
    repeat (4) @(negedge clk_wr);
    check_count("tx_phy0[65] pulses", b_credits, b_handshakes);
    check_count("B handshakes", b_handshakes, N_ENTRIES - N_AR);
    end_test("B credit return");
    errors += uut.u_receive.u_link_asserts.fail_count + uut.u_transmit.u_link_asserts.fail_count;
    $display("%0d tests ok, %0d with errors, %0d errors in all", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
source/ll_pkg.sv
source/ll_link_if.sv
source/ll_online_sync.sv
source/ll_transmit.sv
source/ll_receive.sv
source/ll_phy_link.sv
source/axi_ar_b_master_top.sv
bench/tb_asserts.sv
bench/tb_top.sv
